// ==== hdl/alu_op_pkg.sv ====
package alu_op_pkg;

  // --------------------
  // opcode field
  // --------------------
  localparam int OP_W = 4;                          // opcode width

  // {funct7[5], funct3} style encoding
  localparam logic [OP_W-1:0] ADD_OP  = 4'b0000;    // op1 + op2
  localparam logic [OP_W-1:0] SUB_OP  = 4'b1000;    // op1 - op2
  localparam logic [OP_W-1:0] SLL_OP  = 4'b0001;    // logical left shift
  localparam logic [OP_W-1:0] PASS_OP = 4'b0011;    // result is op2
  localparam logic [OP_W-1:0] XOR_OP  = 4'b0100;    // bitwise xor
  localparam logic [OP_W-1:0] SRL_OP  = 4'b0101;    // logical right shift
  localparam logic [OP_W-1:0] SRA_OP  = 4'b1101;    // arithmetic right shift
  localparam logic [OP_W-1:0] OR_OP   = 4'b0110;    // bitwise or
  localparam logic [OP_W-1:0] AND_OP  = 4'b0111;    // bitwise and

  // --------------------
  // decoded control
  // --------------------
  typedef enum logic [2:0] {
    AL_ADD  = 3'd0,                                 // sum
    AL_SUB  = 3'd1,                                 // difference
    AL_XOR  = 3'd2,
    AL_OR   = 3'd3,
    AL_AND  = 3'd4,
    AL_PASS = 3'd5,                                 // forward op2
    AL_ZERO = 3'd6                                  // path contributes nothing
  } al_mode_e;

  // steers the shifter and the arith/logic path
  typedef struct packed {
    logic     shift_en;                             // result comes from shifter
    logic     shift_left;                           // reverse operand for sll
    logic     shift_arith;                          // sign fill for sra
    al_mode_e al_mode;                              // arith/logic operation
  } alu_ctrl_t;

endpackage

// ==== hdl/alu_data_pkg.sv ====
package alu_data_pkg;

  // --------------------
  // datapath
  // --------------------
  localparam int DATA_W = 32;                       // operand and result width

  // --------------------
  // flow control
  // --------------------
  // queue slots, also the source's credits after reset
  localparam int RES_QUEUE_DEPTH = 4;

  // most output credits the sink may have outstanding
  localparam int SINK_CREDITS_MAX = 8;

  // counter must hold 0 .. SINK_CREDITS_MAX
  localparam int CREDIT_W = $clog2(SINK_CREDITS_MAX + 1);

endpackage

// ==== hdl/alu_mode_decode.sv ====
`timescale 1ns/10ps

module alu_mode_decode (
  input  logic [alu_op_pkg::OP_W-1:0] i_op,         // raw opcode
  output alu_op_pkg::alu_ctrl_t       o_ctrl        // decoded control word
);

  always_comb begin
    // default is the unknown-opcode word, both paths silent
    o_ctrl.shift_en    = 1'b0;
    o_ctrl.shift_left  = 1'b0;
    o_ctrl.shift_arith = 1'b0;
    o_ctrl.al_mode     = alu_op_pkg::AL_ZERO;

    case (i_op)
      alu_op_pkg::ADD_OP:  o_ctrl.al_mode = alu_op_pkg::AL_ADD;
      alu_op_pkg::SUB_OP:  o_ctrl.al_mode = alu_op_pkg::AL_SUB;
      alu_op_pkg::XOR_OP:  o_ctrl.al_mode = alu_op_pkg::AL_XOR;
      alu_op_pkg::OR_OP:   o_ctrl.al_mode = alu_op_pkg::AL_OR;
      alu_op_pkg::AND_OP:  o_ctrl.al_mode = alu_op_pkg::AL_AND;
      alu_op_pkg::PASS_OP: o_ctrl.al_mode = alu_op_pkg::AL_PASS;
      alu_op_pkg::SLL_OP: begin
        o_ctrl.shift_en   = 1'b1;                   // arith path stays at zero
        o_ctrl.shift_left = 1'b1;                   // bit-reverse around the shifter
      end
      alu_op_pkg::SRL_OP: begin
        o_ctrl.shift_en = 1'b1;                     // zero fill
      end
      alu_op_pkg::SRA_OP: begin
        o_ctrl.shift_en    = 1'b1;
        o_ctrl.shift_arith = 1'b1;                  // sign fill
      end
      default: begin
        o_ctrl.al_mode = alu_op_pkg::AL_ZERO;       // merged result is zero
      end
    endcase
  end

endmodule

// ==== hdl/alu_pipe_reg.sv ====
`timescale 1ns/10ps

module alu_pipe_reg #(
  parameter type T = logic                          // stage payload
) (
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_valid,                             // payload qualifier
  input  T     i_data,
  output logic o_valid,
  output T     o_data
);

  // valid bit, the only control state here
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // payload holds its last value through bubbles
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_data <= i_data;
    end
  end

endmodule

// ==== hdl/alu_shifter.sv ====
`timescale 1ns/10ps

module alu_shifter #(
  parameter int DWIDTH = 32                         // operand width
) (
  input  logic [DWIDTH-1:0]     i_op1,              // value to shift
  input  logic [DWIDTH-1:0]     i_op2,              // low bits hold the amount
  input  alu_op_pkg::alu_ctrl_t i_ctrl,
  output logic [DWIDTH-1:0]     o_result            // zero unless shift_en
);

  localparam int SH_W = $clog2(DWIDTH);             // shift amount width

  logic [SH_W-1:0]   shamt;
  logic [DWIDTH-1:0] op1_rev;                       // op1 bit-reversed
  logic [DWIDTH-1:0] shift_in;                      // operand seen by the right shifter
  logic              fill;                          // bit shifted in from the top
  logic [DWIDTH:0]   shift_ext;                     // one extra bit carries the fill
  logic [DWIDTH-1:0] shift_out;
  logic [DWIDTH-1:0] shift_out_rev;

  assign shamt = i_op2[SH_W-1:0];

  // --------------------
  // bit reversal
  // --------------------
  always_comb begin
    for (int i = 0; i < DWIDTH; i++) begin
      op1_rev[i]       = i_op1[DWIDTH-1-i];
      shift_out_rev[i] = shift_out[DWIDTH-1-i];
    end
  end

  // a left shift is a right shift on the reversed operand
  assign shift_in = i_ctrl.shift_left ? op1_rev : i_op1;

  // --------------------
  // single right shifter
  // --------------------
  assign fill      = i_ctrl.shift_arith & shift_in[DWIDTH-1];       // sra only
  assign shift_ext = $signed({fill, shift_in}) >>> shamt;           // fill replicates
  assign shift_out = shift_ext[DWIDTH-1:0];

  // undo the reversal for sll, gate off for non-shift ops
  always_comb begin
    if (!i_ctrl.shift_en) begin
      o_result = '0;
    end else if (i_ctrl.shift_left) begin
      o_result = shift_out_rev;
    end else begin
      o_result = shift_out;
    end
  end

endmodule

// ==== hdl/alu_arith_logic.sv ====
`timescale 1ns/10ps

module alu_arith_logic #(
  parameter int DWIDTH = 32                         // operand width
) (
  input  logic [DWIDTH-1:0]     i_op1,
  input  logic [DWIDTH-1:0]     i_op2,
  input  logic [DWIDTH-1:0]     i_shift_result,     // already gated by the shifter
  input  alu_op_pkg::alu_ctrl_t i_ctrl,
  output logic [DWIDTH-1:0]     o_result            // merged alu result
);

  logic [DWIDTH-1:0] al_result;                     // gated arith/logic value
  logic [DWIDTH-1:0] sum;
  logic [DWIDTH-1:0] diff;

  // --------------------
  // add / subtract
  // --------------------
  assign sum  = i_op1 + i_op2;                      // wraps modulo 2^DWIDTH
  assign diff = i_op1 - i_op2;                      // op1 minus op2

  // --------------------
  // mode select
  // --------------------
  always_comb begin
    case (i_ctrl.al_mode)
      alu_op_pkg::AL_ADD:  al_result = sum;
      alu_op_pkg::AL_SUB:  al_result = diff;
      alu_op_pkg::AL_XOR:  al_result = i_op1 ^ i_op2;
      alu_op_pkg::AL_OR:   al_result = i_op1 | i_op2;
      alu_op_pkg::AL_AND:  al_result = i_op1 & i_op2;
      alu_op_pkg::AL_PASS: al_result = i_op2;       // pass operand 2
      default:             al_result = '0;          // AL_ZERO and unused codes
    endcase
  end

  // only one path is non-zero for any decoded op, so OR merges them
  assign o_result = al_result | i_shift_result;

endmodule

// ==== hdl/alu_result_queue.sv ====
`timescale 1ns/10ps

module alu_result_queue #(
  parameter int DWIDTH = 32,                        // result width
  parameter int DEPTH  = 4                          // entries
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_push,                 // result from stage 2
  input  logic [DWIDTH-1:0] i_data,
  input  logic              i_res_credit,           // sink grants one credit
  output logic              o_res_valid,            // result leaves this cycle
  output logic [DWIDTH-1:0] o_result,
  output logic              o_op_credit             // one credit back to the source
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);         // holds 0 .. DEPTH

  logic [DWIDTH-1:0]                   mem [DEPTH];  // storage, no reset
  logic [PTR_W-1:0]                    wr_ptr;
  logic [PTR_W-1:0]                    rd_ptr;
  logic [CNT_W-1:0]                    count;        // entries held
  logic [alu_data_pkg::CREDIT_W-1:0]   credit_cnt;   // output credits held
  logic                                full;
  logic                                empty;
  logic                                wr_en;
  logic                                pop;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign wr_en = i_push && !full;                   // source credits keep this true
  assign pop   = !empty && (credit_cnt != '0);      // entry and credit both needed

  // --------------------
  // storage and pointers
  // --------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy, push and pop may coincide
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                    // none or both
      endcase
    end
  end

  // --------------------
  // output credits
  // --------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      credit_cnt <= '0;
    end else begin
      case ({i_res_credit, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;   // grant
        2'b01:   credit_cnt <= credit_cnt - 1'b1;   // spend
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // show-ahead read, head entry is always on o_result
  assign o_result    = mem[rd_ptr];
  assign o_res_valid = pop;
  assign o_op_credit = pop;                         // freed slot goes back to the source

endmodule

// ==== hdl/alu_top.sv ====
`timescale 1ns/10ps

module alu_top #(
  parameter int DWIDTH      = alu_data_pkg::DATA_W,           // operand width
  parameter int QUEUE_DEPTH = alu_data_pkg::RES_QUEUE_DEPTH   // result slots
) (
  input  logic                        clk,
  input  logic                        i_rst_n,
  // source side
  input  logic                        i_op_valid,   // only while a credit is held
  input  logic [alu_op_pkg::OP_W-1:0] i_op,
  input  logic [DWIDTH-1:0]           i_op1,
  input  logic [DWIDTH-1:0]           i_op2,
  output logic                        o_op_credit,  // one pulse per freed slot
  // sink side
  input  logic                        i_res_credit, // one pulse per granted credit
  output logic                        o_res_valid,
  output logic [DWIDTH-1:0]           o_result
);

  // --------------------
  // stage payloads
  // --------------------
  typedef struct packed {
    logic [DWIDTH-1:0]     op1;
    logic [DWIDTH-1:0]     op2;
    alu_op_pkg::alu_ctrl_t ctrl;                    // decoded before stage 1
  } stage1_t;

  typedef struct packed {
    logic [DWIDTH-1:0] result;
  } stage2_t;

  alu_op_pkg::alu_ctrl_t ctrl_dec;                  // decoder output
  stage1_t               s1_in;
  stage1_t               s1_out;
  logic                  s1_valid;
  logic [DWIDTH-1:0]     shift_res;                 // shifter path
  logic [DWIDTH-1:0]     exe_res;                   // merged result
  stage2_t               s2_in;
  stage2_t               s2_out;
  logic                  s2_valid;

  // decode in the accept cycle
  alu_mode_decode u_decode (
    .i_op   (i_op),
    .o_ctrl (ctrl_dec)
  );

  assign s1_in = '{op1: i_op1, op2: i_op2, ctrl: ctrl_dec};

  alu_pipe_reg #(.T(stage1_t)) u_stage1 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_op_valid),
    .i_data  (s1_in),
    .o_valid (s1_valid),
    .o_data  (s1_out)
  );

  // --------------------
  // execute between stages
  // --------------------
  alu_shifter #(.DWIDTH(DWIDTH)) u_shifter (
    .i_op1    (s1_out.op1),
    .i_op2    (s1_out.op2),
    .i_ctrl   (s1_out.ctrl),
    .o_result (shift_res)
  );

  alu_arith_logic #(.DWIDTH(DWIDTH)) u_arith_logic (
    .i_op1          (s1_out.op1),
    .i_op2          (s1_out.op2),
    .i_shift_result (shift_res),
    .i_ctrl         (s1_out.ctrl),
    .o_result       (exe_res)
  );

  assign s2_in = '{result: exe_res};

  alu_pipe_reg #(.T(stage2_t)) u_stage2 (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (s1_valid),
    .i_data  (s2_in),
    .o_valid (s2_valid),
    .o_data  (s2_out)
  );

  // stage 2 pushes straight into the queue, no stall path
  alu_result_queue #(.DWIDTH(DWIDTH), .DEPTH(QUEUE_DEPTH)) u_queue (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_push       (s2_valid),
    .i_data       (s2_out.result),
    .i_res_credit (i_res_credit),
    .o_res_valid  (o_res_valid),
    .o_result     (o_result),
    .o_op_credit  (o_op_credit)
  );

endmodule

// ==== test/alu_props.sv ====
`timescale 1ns/10ps

module alu_props (
  input logic                              clk,
  input logic                              i_rst_n,
  input logic                              i_push,       // stage 2 write
  input logic                              i_full,
  input logic                              i_res_credit, // grant seen at the port
  input logic                              i_res_valid,
  input logic                              i_op_credit,
  input logic [alu_data_pkg::CREDIT_W-1:0] i_credit_cnt  // output credits held
);

  // grants minus results, tracked from the sink port alone
  logic [alu_data_pkg::CREDIT_W-1:0] credit_seen;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      credit_seen <= '0;
    end else begin
      case ({i_res_credit, i_res_valid})
        2'b10:   credit_seen <= credit_seen + 1'b1;
        2'b01:   credit_seen <= credit_seen - 1'b1;
        default: credit_seen <= credit_seen;
      endcase
    end
  end

  // --------------------
  // queue checks
  // --------------------
  a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n) !(i_push && i_full))
    else $error("push into a full result queue");

  a_valid_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_res_valid |-> (credit_seen != '0))
    else $error("result valid with no output credit held");

  a_credit_max: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_credit_cnt <= alu_data_pkg::SINK_CREDITS_MAX)
    else $error("output credit count above the sink limit");

  // state is cleared one edge into reset
  a_reset_quiet: assert property (@(posedge clk) !i_rst_n |=> (!i_res_valid && !i_op_credit))
    else $error("result valid or credit return during reset");

endmodule

bind alu_result_queue alu_props u_props (
  .clk          (clk),
  .i_rst_n      (i_rst_n),
  .i_push       (i_push),
  .i_full       (full),
  .i_res_credit (i_res_credit),
  .i_res_valid  (o_res_valid),
  .i_op_credit  (o_op_credit),
  .i_credit_cnt (credit_cnt)
);

// ==== test/alu_tb.sv ====
`timescale 1ns/10ps

module alu_tb;

  localparam int DW       = alu_data_pkg::DATA_W;
  localparam int SH_W     = $clog2(DW);
  localparam int OPW      = alu_op_pkg::OP_W;
  localparam int WAIT_MAX = 500;                    // cycles before any wait gives up

  logic          clk        = 1'b0;
  logic          rst_n;
  logic          op_valid;
  logic [OPW-1:0] op_code;
  logic [DW-1:0] op1;
  logic [DW-1:0] op2;
  logic          res_credit = 1'b0;                 // only the sink process drives it
  logic          op_credit;
  logic          res_valid;
  logic [DW-1:0] result;

  int ops_sent         = 0;                         // source credits spent
  int op_credit_pulses = 0;                         // source credits returned
  int res_valid_cycles = 0;
  int grants           = 0;                         // output credits granted by the sink
  int hold_cycles      = 0;                         // sink stall stretch
  int grant_mode       = 0;                         // 0 none, 1 always, 2 random, 3 on request
  int grant_req        = 0;                         // single grants still to hand out

  logic [DW-1:0]  exp_q [$];                        // expected results in order
  string          name_q [$];
  logic [DW-1:0]  exp_val;
  string          exp_name;
  logic [OPW-1:0] op_pool [10];

  // stimulus table
  string          tbl_name [$];
  logic [OPW-1:0] tbl_op [$];
  logic [DW-1:0]  tbl_a [$];
  logic [DW-1:0]  tbl_b [$];
  logic [DW-1:0]  tbl_exp [$];

  always #4 clk = ~clk;                             // 8 ns period

  alu_top #(
    .DWIDTH      (DW),
    .QUEUE_DEPTH (alu_data_pkg::RES_QUEUE_DEPTH)
  ) u_dut (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_op_valid   (op_valid),
    .i_op         (op_code),
    .i_op1        (op1),
    .i_op2        (op2),
    .o_op_credit  (op_credit),
    .i_res_credit (res_credit),
    .o_res_valid  (res_valid),
    .o_result     (result)
  );

  // --------------------
  // helpers
  // --------------------
  task automatic fail_run(input string what);
    $display("Error: %s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [DW-1:0] expected,
                         input logic [DW-1:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // reference model, straight from the opcode rules
  function automatic logic [DW-1:0] ref_result(input logic [OPW-1:0] op,
                                               input logic [DW-1:0] a, input logic [DW-1:0] b);
    logic [SH_W-1:0] sh;
    sh = b[SH_W-1:0];                               // upper bits of op2 ignored
    case (op)
      alu_op_pkg::ADD_OP:  ref_result = a + b;
      alu_op_pkg::SUB_OP:  ref_result = a - b;
      alu_op_pkg::XOR_OP:  ref_result = a ^ b;
      alu_op_pkg::OR_OP:   ref_result = a | b;
      alu_op_pkg::AND_OP:  ref_result = a & b;
      alu_op_pkg::PASS_OP: ref_result = b;
      alu_op_pkg::SLL_OP:  ref_result = a << sh;
      alu_op_pkg::SRL_OP:  ref_result = a >> sh;
      alu_op_pkg::SRA_OP:  ref_result = $signed(a) >>> sh;   // sign fill
      default:             ref_result = '0;         // unknown opcode
    endcase
  endfunction

  task automatic add_row(input string name, input logic [OPW-1:0] op, input logic [DW-1:0] a,
                         input logic [DW-1:0] b, input logic [DW-1:0] expected);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_exp.push_back(expected);
  endtask

  // spends one source credit, waits at the edge until one is held
  task automatic send_op(input string name, input logic [OPW-1:0] op, input logic [DW-1:0] a,
                         input logic [DW-1:0] b, input logic [DW-1:0] expected);
    int waited;
    waited = 0;
    @(posedge clk);
    while (alu_data_pkg::RES_QUEUE_DEPTH - ops_sent + op_credit_pulses <= 0) begin
      op_valid <= 1'b0;                             // bubble while out of credits
      if (waited >= WAIT_MAX) begin
        fail_run("timed out waiting for an input credit");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
    op_valid <= 1'b1;
    op_code  <= op;
    op1      <= a;
    op2      <= b;
    ops_sent++;
    exp_q.push_back(expected);
    name_q.push_back(name);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    op_valid <= 1'b0;
  endtask

  task automatic set_grant_mode(input int mode);
    @(negedge clk);                                 // away from the sink's edge
    grant_mode = mode;
  endtask

  // sink hands out exactly one output credit
  task automatic grant_one();
    @(negedge clk);
    grant_req  = 1;
    grant_mode = 3;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= WAIT_MAX) begin
        fail_run("timed out waiting for results to drain");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
  endtask

  // --------------------
  // sink and monitor
  // --------------------
  always @(posedge clk) begin
    if (!rst_n || grant_mode == 0) begin
      res_credit <= 1'b0;
    end else if (grant_mode == 3) begin
      if (grant_req != 0) begin                     // requested grants only
        res_credit <= 1'b1;
        grants++;
        grant_req--;
      end else begin
        res_credit <= 1'b0;
      end
    end else if (hold_cycles != 0) begin
      res_credit  <= 1'b0;                          // stall stretch
      hold_cycles = hold_cycles - 1;
    end else if (grants - res_valid_cycles >= alu_data_pkg::SINK_CREDITS_MAX) begin
      res_credit <= 1'b0;                           // outstanding limit reached
    end else if (grant_mode == 2 && $urandom_range(9, 0) == 0) begin
      res_credit  <= 1'b0;
      hold_cycles = $urandom_range(24, 8);
    end else if (grant_mode == 1 || $urandom_range(1, 0) == 1) begin
      res_credit <= 1'b1;
      grants++;
    end else begin
      res_credit <= 1'b0;
    end
  end

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (op_credit) begin
        op_credit_pulses++;
      end
      if (res_valid) begin
        res_valid_cycles++;
        if (exp_q.size() == 0) begin
          fail_run("result arrived with no operation outstanding");
        end else begin
          exp_val  = exp_q.pop_front();
          exp_name = name_q.pop_front();
          compare(exp_name, exp_val, result);       // order and value
        end
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    logic [OPW-1:0] rnd_op;
    logic [DW-1:0]  ra;
    logic [DW-1:0]  rb;
    int             leftover;
    rst_n    = 1'b0;
    op_valid = 1'b0;
    op_code  = '0;
    op1      = '0;
    op2      = '0;
    void'($urandom(83));
    op_pool  = '{alu_op_pkg::ADD_OP, alu_op_pkg::SUB_OP, alu_op_pkg::XOR_OP,
                 alu_op_pkg::OR_OP, alu_op_pkg::AND_OP, alu_op_pkg::PASS_OP,
                 alu_op_pkg::SLL_OP, alu_op_pkg::SRL_OP, alu_op_pkg::SRA_OP, 4'b1010};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    repeat (8) begin                                // no credits, no ops, nothing moves
      @(negedge clk);
      compare("idle_res_valid", '0, DW'(res_valid));
      compare("idle_op_credit", '0, DW'(op_credit));
    end

    add_row("add",       alu_op_pkg::ADD_OP,  32'h0000_0005, 32'h0000_0007, 32'h0000_000C);
    add_row("add_wrap",  alu_op_pkg::ADD_OP,  32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001);
    add_row("sub",       alu_op_pkg::SUB_OP,  32'h0000_0010, 32'h0000_0003, 32'h0000_000D);
    add_row("sub_wrap",  alu_op_pkg::SUB_OP,  32'h0000_0001, 32'h0000_0002, 32'hFFFF_FFFF);
    add_row("xor",       alu_op_pkg::XOR_OP,  32'hF0F0_1234, 32'h0FF0_FFFF, 32'hFF00_EDCB);
    add_row("or",        alu_op_pkg::OR_OP,   32'hA500_0001, 32'h005A_0100, 32'hA55A_0101);
    add_row("and",       alu_op_pkg::AND_OP,  32'hDEAD_BEEF, 32'h0F0F_F00F, 32'h0E0D_B00F);
    add_row("pass",      alu_op_pkg::PASS_OP, 32'h1234_5678, 32'hCAFE_F00D, 32'hCAFE_F00D);
    add_row("sll",       alu_op_pkg::SLL_OP,  32'h0000_0001, 32'h0000_0004, 32'h0000_0010);
    add_row("sll_hi",    alu_op_pkg::SLL_OP,  32'h8000_0003, 32'hFFFF_FFE1, 32'h0000_0006);
    add_row("srl_neg",   alu_op_pkg::SRL_OP,  32'h8000_0000, 32'h0000_001F, 32'h0000_0001);
    add_row("srl_zero",  alu_op_pkg::SRL_OP,  32'h1234_5678, 32'h0000_0020, 32'h1234_5678);
    add_row("sra_neg",   alu_op_pkg::SRA_OP,  32'hF000_0000, 32'h0000_0004, 32'hFF00_0000);
    add_row("sra_hi",    alu_op_pkg::SRA_OP,  32'h8000_0000, 32'h0000_0FE3, 32'hF000_0000);
    add_row("sra_pos",   alu_op_pkg::SRA_OP,  32'h7000_0000, 32'h0000_0004, 32'h0700_0000);
    add_row("unknown_2", 4'b0010,             32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
    add_row("unknown_f", 4'b1111,             32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);

    set_grant_mode(1);
    for (int i = 0; i < tbl_name.size(); i++) begin
      compare({tbl_name[i], "_model"}, tbl_exp[i], ref_result(tbl_op[i], tbl_a[i], tbl_b[i]));
      send_op(tbl_name[i], tbl_op[i], tbl_a[i], tbl_b[i], tbl_exp[i]);
    end

    set_grant_mode(2);                              // sink withholds credits in stretches
    for (int n = 0; n < 80; n++) begin
      rnd_op = op_pool[$urandom_range(9, 0)];
      ra     = $urandom;
      rb     = $urandom;                            // full width, upper shift bits set too
      if ($urandom_range(3, 0) == 0) begin
        idle_cycle();
      end
      send_op($sformatf("rand_%0d", n), rnd_op, ra, rb, ref_result(rnd_op, ra, rb));
    end
    idle_cycle();

    set_grant_mode(1);
    wait_drain();
    set_grant_mode(0);
    repeat (3) @(posedge clk);

    // use up the credits the sink still has outstanding
    leftover = grants - res_valid_cycles;
    for (int k = 0; k < leftover; k++) begin
      send_op($sformatf("spend_%0d", k), alu_op_pkg::ADD_OP, DW'(k), DW'(1), DW'(k + 1));
    end
    idle_cycle();
    wait_drain();
    repeat (4) @(posedge clk);

    // every credit is spent, so a new result must wait in the queue
    send_op("no_credit", alu_op_pkg::XOR_OP, 32'h0000_00FF, 32'h0000_0F0F, 32'h0000_0FF0);
    idle_cycle();
    repeat (8) begin
      @(negedge clk);
      compare("no_credit_valid", '0, DW'(res_valid));
    end
    grant_one();
    wait_drain();
    repeat (4) @(posedge clk);

    compare("credits_spent", DW'(grants), DW'(res_valid_cycles));
    compare("op_credit_pulses", DW'(ops_sent), DW'(op_credit_pulses));
    compare("res_valid_cycles", DW'(ops_sent), DW'(res_valid_cycles));
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/alu_op_pkg.sv
hdl/alu_data_pkg.sv
hdl/alu_mode_decode.sv
hdl/alu_pipe_reg.sv
hdl/alu_shifter.sv
hdl/alu_arith_logic.sv
hdl/alu_result_queue.sv
hdl/alu_top.sv
test/alu_props.sv
test/alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the ALU testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alu_tb -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Valu_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Testbench passed$"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
